// File: prune_trace.txt
# name, 64 initial words, 64 expected words (hex, row-major, 4 words per row)
# then expected updates and passes (decimal)
empty
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
0 1
isolated
01 00 00 80 00 00 00 00 00 00 00 00 00 00 ff 00
00 00 00 00 80 01 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 18 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 80
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
15 2
blocks
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 c0 01 00 00 c0 01 00
00 c0 01 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 e0 00 00 00 e0 00 00 00 e0
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
18 3

// File: files.f
grid_pkg.sv
grid_bank.sv
grid_host_port.sv
prune_engine.sv
prune_run_ctrl.sv
prune_top.sv
prune_checker.sv
prune_tb.sv

// File: run.sh
#!/bin/sh
# build and run from the project root
verilator --binary --timing --assert -f files.f --top-module prune_tb \
    -o prune_sim > build.log 2>&1 \
    && ./obj_dir/prune_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "^test passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// File: prune_tb.sv
`timescale 1ns/100ps

module prune_tb
    import grid_pkg::*;
;

    localparam int max_tests = 16;
    localparam int num_words = grid_rows * words_per_row;
    localparam int run_limit = (grid_rows + 2) * 400;

    logic                   clock;
    logic                   reset;
    logic                   host_we_i;
    logic                   host_re_i;
    logic [bank_addr_w-1:0] host_addr_i;
    logic [word_w-1:0]      host_wdata_i;
    logic [word_w-1:0]      host_rdata_o;
    logic                   host_rvalid_o;
    logic                   start_i;
    logic                   busy_o;
    logic                   done_o;
    logic [count_w-1:0]     updates_o;
    logic [count_w-1:0]     passes_o;

    string       names [max_tests];
    logic [7:0]  init_words [max_tests][num_words];
    logic [7:0]  final_words [max_tests][num_words];
    int          exp_updates [max_tests];
    int          exp_passes [max_tests];
    int          test_count;
    logic        trace_loaded;
    int          errors;

    prune_top dut_i (
        .clock         (clock),
        .reset         (reset),
        .host_we_i     (host_we_i),
        .host_re_i     (host_re_i),
        .host_addr_i   (host_addr_i),
        .host_wdata_i  (host_wdata_i),
        .host_rdata_o  (host_rdata_o),
        .host_rvalid_o (host_rvalid_o),
        .start_i       (start_i),
        .busy_o        (busy_o),
        .done_o        (done_o),
        .updates_o     (updates_o),
        .passes_o      (passes_o)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %0t %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic write_word(input int addr, input logic [7:0] data);
        host_addr_i  = bank_addr_w'(addr);
        host_wdata_i = data;
        host_we_i    = 1'b1;
        @(negedge clock);
        host_we_i = 1'b0;
    endtask

    task automatic read_word(input int addr, output logic [7:0] data);
        host_addr_i = bank_addr_w'(addr);
        host_re_i   = 1'b1;
        @(negedge clock);
        host_re_i = 1'b0;
        check_value("host_rvalid_o", 32'(1'b1), 32'(host_rvalid_o));
        data = host_rdata_o;
    endtask

    task automatic check_grid(input int t, input logic check_final);
        logic [7:0] data;
        for (int a = 0; a < num_words; a++) begin
            read_word(a, data);
            if (check_final) begin
                check_value($sformatf("host_rdata_o[%0d]", a), 32'(final_words[t][a]),
                            32'(data));
            end else begin
                check_value($sformatf("host_rdata_o[%0d]", a), 32'(init_words[t][a]),
                            32'(data));
            end
        end
    endtask

    // one run, optionally hammering the bank with host writes while busy
    task automatic run_grid(input int upd, input int passes, input logic poke);
        int cycles;
        start_i = 1'b1;
        @(negedge clock);
        start_i = 1'b0;
        check_value("busy_o", 32'(1'b1), 32'(busy_o));
        if (poke) begin
            for (int a = 0; a < 4; a++) begin
                write_word(a * 9, 8'hff);
            end
        end
        cycles = 0;
        while (!done_o && cycles < run_limit * 3) begin
            @(negedge clock);
            cycles++;
        end
        if (!done_o) begin
            $display("done_o never arrived after %0d cycles", cycles);
            errors++;
        end else begin
            check_value("busy_o", 32'(1'b0), 32'(busy_o));
            check_value("updates_o", 32'(upd), 32'(updates_o));
            check_value("passes_o", 32'(passes), 32'(passes_o));
        end
        @(negedge clock);
    endtask

    task automatic load_trace();
        int    fd;
        int    code;
        int    value;
        logic  short_entry;
        string line;
        string name;
        fd = $fopen("prune_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open prune_trace.txt");
            errors++;
        end else begin
            // two header lines describe the columns
            code = $fgets(line, fd);
            code = $fgets(line, fd);
            while (test_count < max_tests && $fscanf(fd, "%s", name) == 1) begin
                short_entry = 1'b0;
                names[test_count] = name;
                for (int a = 0; a < num_words; a++) begin
                    code = $fscanf(fd, "%h", value);
                    if (code != 1) begin
                        short_entry = 1'b1;
                    end
                    init_words[test_count][a] = value[7:0];
                end
                for (int a = 0; a < num_words; a++) begin
                    code = $fscanf(fd, "%h", value);
                    if (code != 1) begin
                        short_entry = 1'b1;
                    end
                    final_words[test_count][a] = value[7:0];
                end
                code = $fscanf(fd, "%d", exp_updates[test_count]);
                if (code != 1) begin
                    short_entry = 1'b1;
                end
                code = $fscanf(fd, "%d", exp_passes[test_count]);
                if (code != 1) begin
                    short_entry = 1'b1;
                end
                if (short_entry) begin
                    $display("trace entry %s is incomplete", name);
                    errors++;
                end
                test_count++;
            end
            $fclose(fd);
        end
    endtask

    initial begin
        int start_errors;
        host_we_i    = 1'b0;
        host_re_i    = 1'b0;
        host_addr_i  = '0;
        host_wdata_i = '0;
        start_i      = 1'b0;
        reset        = 1'b1;
        errors       = 0;
        test_count   = 0;
        trace_loaded = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        for (int t = 0; t < test_count; t++) begin
            start_errors = errors;
            for (int a = 0; a < num_words; a++) begin
                write_word(a, init_words[t][a]);
            end
            check_grid(t, 1'b0);
            run_grid(exp_updates[t], exp_passes[t], 1'b1);
            check_grid(t, 1'b1);
            // settled grid, counters start from zero again
            run_grid(0, 1, 1'b0);
            check_grid(t, 1'b1);
            $display("%s: %0d errors", names[t], errors - start_errors);
        end
        $display("%0d tests run, %0d errors", test_count, errors);
        if (errors == 0 && test_count > 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        longint limit_ns;
        wait (trace_loaded);
        limit_ns = longint'(test_count) * (grid_rows + 2) * 400 * 4;
        #(limit_ns);
        $display("watchdog expired before the tests finished");
        $display("test failed");
        $finish;
    end

endmodule

// File: prune_checker.sv
`timescale 1ns/100ps

module prune_checker (
    input logic clock,
    input logic reset,
    input logic busy_i,
    input logic done_i,
    input logic host_re_i,
    input logic host_rvalid_i,
    input logic eng_re_i,
    input logic eng_we_i
);

    // the run ends in the cycle that done pulses
    assert property (@(posedge clock) disable iff (reset)
        done_i |-> (!busy_i && $past(busy_i)))
        else $error("done_o pulsed without busy_o falling");

    assert property (@(posedge clock) disable iff (reset)
        $fell(busy_i) |-> done_i)
        else $error("busy_o fell without done_o");

    // host read accepted while idle
    assert property (@(posedge clock) disable iff (reset)
        (host_re_i && !busy_i) |=> host_rvalid_i)
        else $error("host_rvalid_o missing after an accepted read");

    assert property (@(posedge clock) disable iff (reset)
        !(eng_re_i && eng_we_i))
        else $error("bank read and written in the same cycle");

endmodule

bind prune_top prune_checker checker_i (
    .clock         (clock),
    .reset         (reset),
    .busy_i        (busy_o),
    .done_i        (done_o),
    .host_re_i     (host_re_i),
    .host_rvalid_i (host_rvalid_o),
    .eng_re_i      (eng_re),
    .eng_we_i      (eng_we)
);

// File: prune_top.sv
`timescale 1ns/100ps

module prune_top
    import grid_pkg::*;
#(
    parameter int grid_rows = grid_pkg::grid_rows,
    parameter int grid_cols = grid_pkg::grid_cols,
    parameter int word_w    = grid_pkg::word_w
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   host_we_i,
    input  logic                   host_re_i,
    input  logic [bank_addr_w-1:0] host_addr_i,
    input  logic [word_w-1:0]      host_wdata_i,
    output logic [word_w-1:0]      host_rdata_o,
    output logic                   host_rvalid_o,
    input  logic                   start_i,
    output logic                   busy_o,
    output logic                   done_o,
    output logic [count_w-1:0]     updates_o,
    output logic [count_w-1:0]     passes_o
);

    logic                   pass_start;
    logic                   pass_done;
    logic [count_w-1:0]     pass_updates;
    logic                   eng_re;
    logic                   eng_we;
    logic [bank_addr_w-1:0] eng_addr;
    logic [word_w-1:0]      eng_wdata;
    logic [word_w-1:0]      eng_rdata;

    grid_host_port #(
        .grid_rows (grid_rows),
        .grid_cols (grid_cols),
        .word_w    (word_w)
    ) host_port_i (
        .clock         (clock),
        .reset         (reset),
        .host_we_i     (host_we_i),
        .host_re_i     (host_re_i),
        .host_addr_i   (host_addr_i),
        .host_wdata_i  (host_wdata_i),
        .host_rdata_o  (host_rdata_o),
        .host_rvalid_o (host_rvalid_o),
        .busy_i        (busy_o),
        .eng_we_i      (eng_we),
        .eng_addr_i    (eng_addr),
        .eng_wdata_i   (eng_wdata),
        .eng_rdata_o   (eng_rdata)
    );

    prune_engine #(
        .grid_rows (grid_rows),
        .grid_cols (grid_cols),
        .word_w    (word_w)
    ) engine_i (
        .clock          (clock),
        .reset          (reset),
        .pass_start_i   (pass_start),
        .pass_done_o    (pass_done),
        .pass_updates_o (pass_updates),
        .eng_re_o       (eng_re),
        .eng_we_o       (eng_we),
        .eng_addr_o     (eng_addr),
        .eng_wdata_o    (eng_wdata),
        .eng_rdata_i    (eng_rdata)
    );

    prune_run_ctrl run_ctrl_i (
        .clock          (clock),
        .reset          (reset),
        .start_i        (start_i),
        .pass_done_i    (pass_done),
        .pass_updates_i (pass_updates),
        .pass_start_o   (pass_start),
        .busy_o         (busy_o),
        .done_o         (done_o),
        .updates_o      (updates_o),
        .passes_o       (passes_o)
    );

endmodule

// File: prune_run_ctrl.sv
`timescale 1ns/100ps

module prune_run_ctrl
    import grid_pkg::*;
(
    input  logic               clock,
    input  logic               reset,
    input  logic               start_i,
    input  logic               pass_done_i,
    input  logic [count_w-1:0] pass_updates_i,
    output logic               pass_start_o,
    output logic               busy_o,
    output logic               done_o,
    output logic [count_w-1:0] updates_o,
    output logic [count_w-1:0] passes_o
);

    localparam logic st_idle = 1'b0;
    localparam logic st_run  = 1'b1;

    logic state_q;

    assign busy_o = (state_q == st_run);

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q      <= st_idle;
            pass_start_o <= 1'b0;
            done_o       <= 1'b0;
            updates_o    <= '0;
            passes_o     <= '0;
        end else begin
            pass_start_o <= 1'b0;
            done_o       <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (start_i) begin
                        state_q      <= st_run;
                        pass_start_o <= 1'b1;
                        updates_o    <= '0;
                        passes_o     <= '0;
                    end
                end
                default: begin
                    if (pass_done_i) begin
                        updates_o <= updates_o + pass_updates_i;
                        passes_o  <= passes_o + 1'b1;
                        // a pass with no clears ends the run
                        if (pass_updates_i != '0) begin
                            pass_start_o <= 1'b1;
                        end else begin
                            state_q <= st_idle;
                            done_o  <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// File: prune_engine.sv
`timescale 1ns/100ps

module prune_engine
    import grid_pkg::*;
#(
    parameter int grid_rows = grid_pkg::grid_rows,
    parameter int grid_cols = grid_pkg::grid_cols,
    parameter int word_w    = grid_pkg::word_w
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   pass_start_i,
    output logic                   pass_done_o,
    output logic [count_w-1:0]     pass_updates_o,
    output logic                   eng_re_o,
    output logic                   eng_we_o,
    output logic [bank_addr_w-1:0] eng_addr_o,
    output logic [word_w-1:0]      eng_wdata_o,
    input  logic [word_w-1:0]      eng_rdata_i
);

    localparam int col_w = $clog2(grid_cols);

    localparam logic [word_addr_w-1:0] last_word = word_addr_w'(grid_cols / word_w - 1);
    localparam logic [row_addr_w-1:0]  last_row  = row_addr_w'(grid_rows - 1);
    localparam logic [col_w-1:0]       last_col  = col_w'(grid_cols - 1);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_fetch = 2'd1;
    localparam logic [1:0] st_scan  = 2'd2;
    localparam logic [1:0] st_write = 2'd3;

    logic [1:0]             state_q;
    logic [row_addr_w-1:0]  row_q;
    logic [row_addr_w-1:0]  fetch_row;
    logic [word_addr_w-1:0] word_q;
    logic [word_addr_w-1:0] rd_word_q;
    logic [col_w-1:0]       col_q;
    logic                   fetch_issued_q;
    logic                   rd_valid_q;
    logic                   prime_q;
    logic                   fetch_last;

    // row registers, bit 0 is the window column while scanning
    logic [grid_cols-1:0] above_q;
    logic [grid_cols-1:0] centre_q;
    logic [grid_cols-1:0] below_q;
    logic [grid_cols-1:0] below_next;
    logic [grid_cols-1:0] centre_pruned;

    logic       has_left;
    logic       has_right;
    logic [7:0] nbr;
    logic [3:0] degree;
    logic       prune;

    // the first fetch of a pass loads row 0, later ones the row below centre
    assign fetch_row  = prime_q ? '0 : row_q + 1'b1;
    assign fetch_last = rd_valid_q && (rd_word_q == last_word);

    always_comb begin
        below_next = below_q;
        if (rd_valid_q) begin
            below_next[rd_word_q*word_w +: word_w] = eng_rdata_i;
        end
    end

    // 3x3 window, cells past the row ends count as clear
    always_comb begin
        has_left  = (col_q != '0);
        has_right = (col_q != last_col);
        nbr[0] = has_left  && above_q[grid_cols-1];
        nbr[1] = above_q[0];
        nbr[2] = has_right && above_q[1];
        nbr[3] = has_left  && centre_q[grid_cols-1];
        nbr[4] = has_right && centre_q[1];
        nbr[5] = has_left  && below_q[grid_cols-1];
        nbr[6] = below_q[0];
        nbr[7] = has_right && below_q[1];
        degree = '0;
        for (int i = 0; i < 8; i++) begin
            degree = degree + 4'(nbr[i]);
        end
        prune = centre_q[0] && (degree < 4'd4);
        centre_pruned = centre_q;
        if (prune) begin
            centre_pruned[0] = 1'b0;
        end
    end

    assign eng_re_o    = (state_q == st_fetch) && !fetch_issued_q;
    assign eng_we_o    = (state_q == st_write);
    assign eng_addr_o  = {eng_we_o ? row_q : fetch_row, word_q};
    assign eng_wdata_o = centre_q[word_q*word_w +: word_w];

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q        <= st_idle;
            pass_done_o    <= 1'b0;
            pass_updates_o <= '0;
            row_q          <= '0;
            word_q         <= '0;
            rd_word_q      <= '0;
            col_q          <= '0;
            fetch_issued_q <= 1'b0;
            rd_valid_q     <= 1'b0;
            prime_q        <= 1'b0;
        end else begin
            pass_done_o <= 1'b0;
            rd_valid_q  <= eng_re_o;
            rd_word_q   <= word_q;
            case (state_q)
                st_idle: begin
                    if (pass_start_i) begin
                        state_q        <= st_fetch;
                        prime_q        <= 1'b1;
                        row_q          <= '0;
                        word_q         <= '0;
                        fetch_issued_q <= 1'b0;
                        pass_updates_o <= '0;
                    end
                end
                st_fetch: begin
                    if (!fetch_issued_q) begin
                        word_q <= word_q + 1'b1;
                        if (word_q == last_word) begin
                            fetch_issued_q <= 1'b1;
                        end
                    end
                    if (fetch_last) begin
                        word_q <= '0;
                        if (prime_q) begin
                            // row 0 is in place, now fetch its lower neighbour
                            prime_q        <= 1'b0;
                            fetch_issued_q <= 1'b0;
                        end else begin
                            state_q <= st_scan;
                            col_q   <= '0;
                        end
                    end
                end
                st_scan: begin
                    col_q <= col_q + 1'b1;
                    if (prune) begin
                        pass_updates_o <= pass_updates_o + 1'b1;
                    end
                    if (col_q == last_col) begin
                        state_q <= st_write;
                        word_q  <= '0;
                    end
                end
                default: begin
                    word_q <= word_q + 1'b1;
                    if (word_q == last_word) begin
                        if (row_q == last_row) begin
                            state_q     <= st_idle;
                            pass_done_o <= 1'b1;
                        end else begin
                            row_q <= row_q + 1'b1;
                            // bottom row has a zero row below, nothing to fetch
                            if (row_q + 1'b1 == last_row) begin
                                state_q <= st_scan;
                                col_q   <= '0;
                            end else begin
                                state_q        <= st_fetch;
                                fetch_issued_q <= 1'b0;
                            end
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        case (state_q)
            st_idle: begin
                if (pass_start_i) begin
                    above_q <= '0;
                end
            end
            st_fetch: begin
                if (fetch_last && prime_q) begin
                    centre_q <= below_next;
                end else begin
                    below_q <= below_next;
                end
            end
            st_scan: begin
                // rotate right, a full row of shifts restores the alignment
                above_q  <= {above_q[0], above_q[grid_cols-1:1]};
                centre_q <= {centre_pruned[0], centre_pruned[grid_cols-1:1]};
                below_q  <= {below_q[0], below_q[grid_cols-1:1]};
            end
            default: begin
                if (word_q == last_word && row_q != last_row) begin
                    above_q  <= centre_q;
                    centre_q <= below_q;
                    below_q  <= '0;
                end
            end
        endcase
    end

endmodule

// File: grid_host_port.sv
`timescale 1ns/100ps

module grid_host_port
    import grid_pkg::*;
#(
    parameter int grid_rows = grid_pkg::grid_rows,
    parameter int grid_cols = grid_pkg::grid_cols,
    parameter int word_w    = grid_pkg::word_w
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   host_we_i,
    input  logic                   host_re_i,
    input  logic [bank_addr_w-1:0] host_addr_i,
    input  logic [word_w-1:0]      host_wdata_i,
    output logic [word_w-1:0]      host_rdata_o,
    output logic                   host_rvalid_o,
    input  logic                   busy_i,
    input  logic                   eng_we_i,
    input  logic [bank_addr_w-1:0] eng_addr_i,
    input  logic [word_w-1:0]      eng_wdata_i,
    output logic [word_w-1:0]      eng_rdata_o
);

    logic                   bank_we;
    logic [bank_addr_w-1:0] bank_addr;
    logic [word_w-1:0]      bank_wdata;
    logic [word_w-1:0]      bank_rdata;

    // engine owns the bank for the whole run, host strobes are dropped
    assign bank_we    = busy_i ? eng_we_i    : host_we_i;
    assign bank_addr  = busy_i ? eng_addr_i  : host_addr_i;
    assign bank_wdata = busy_i ? eng_wdata_i : host_wdata_i;

    // host read pending, data is on the bank output one cycle later
    always_ff @(posedge clock) begin
        if (reset) begin
            host_rvalid_o <= 1'b0;
        end else begin
            host_rvalid_o <= host_re_i && !busy_i;
        end
    end

    assign host_rdata_o = bank_rdata;
    assign eng_rdata_o  = bank_rdata;

    grid_bank #(
        .grid_rows (grid_rows),
        .grid_cols (grid_cols),
        .word_w    (word_w)
    ) bank_i (
        .clock   (clock),
        .reset   (reset),
        .we_i    (bank_we),
        .addr_i  (bank_addr),
        .wdata_i (bank_wdata),
        .rdata_o (bank_rdata)
    );

endmodule

// File: grid_bank.sv
`timescale 1ns/100ps

module grid_bank
    import grid_pkg::*;
#(
    parameter int grid_rows = grid_pkg::grid_rows,
    parameter int grid_cols = grid_pkg::grid_cols,
    parameter int word_w    = grid_pkg::word_w
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   we_i,
    input  logic [bank_addr_w-1:0] addr_i,
    input  logic [word_w-1:0]      wdata_i,
    output logic [word_w-1:0]      rdata_o
);

    localparam int depth = grid_rows * (grid_cols / word_w);

    logic [word_w-1:0] mem [depth];

    // write port
    always_ff @(posedge clock) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    // registered read of the current address, every cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            rdata_o <= '0;
        end else begin
            rdata_o <= mem[addr_i];
        end
    end

endmodule

// File: grid_pkg.sv
package grid_pkg;

    // cells held in one bank word
    localparam int word_w = 8;

    // grid geometry
    localparam int grid_cols = 32;
    localparam int grid_rows = 16;

    localparam int words_per_row = grid_cols / word_w;

    // bank address is {row, word}, words_per_row is a power of two
    localparam int row_addr_w  = $clog2(grid_rows);
    localparam int word_addr_w = $clog2(words_per_row);
    localparam int bank_addr_w = row_addr_w + word_addr_w;

    // width of the update and pass counters
    localparam int count_w = 16;

endpackage
